//--- jvm_defines.svh
`ifndef JVM_DEFINES_SVH
`define JVM_DEFINES_SVH

// Operand stack word width
`define JVM_DATA_W 32

// Operand stack entries
`define JVM_STACK_DEPTH 16

// Local variable slots
`define JVM_NUM_LOCALS 16

// Depth counter holds 0 through JVM_STACK_DEPTH
`define JVM_DEPTH_W ($clog2(`JVM_STACK_DEPTH) + 1)

// Local variable index
`define JVM_LIDX_W $clog2(`JVM_NUM_LOCALS)

`endif

//--- jvm_isa_pkg.sv
package jvm_isa_pkg;

    // Constant pushes
    localparam logic [7:0] OP_NOP       = 8'h00;
    localparam logic [7:0] OP_ICONST_M1 = 8'h02;
    localparam logic [7:0] OP_ICONST_0  = 8'h03;
    localparam logic [7:0] OP_ICONST_5  = 8'h08;
    localparam logic [7:0] OP_BIPUSH    = 8'h10;
    localparam logic [7:0] OP_SIPUSH    = 8'h11;
    localparam logic [7:0] OP_LDC       = 8'h12;

    // Loads and stores
    localparam logic [7:0] OP_ILOAD     = 8'h15;
    localparam logic [7:0] OP_ALOAD     = 8'h19;
    localparam logic [7:0] OP_ILOAD_0   = 8'h1a;
    localparam logic [7:0] OP_ILOAD_3   = 8'h1d;
    localparam logic [7:0] OP_IALOAD    = 8'h2e;
    localparam logic [7:0] OP_BALOAD    = 8'h33;
    localparam logic [7:0] OP_ISTORE    = 8'h36;
    localparam logic [7:0] OP_ASTORE    = 8'h3a;
    localparam logic [7:0] OP_ISTORE_0  = 8'h3b;
    localparam logic [7:0] OP_ISTORE_3  = 8'h3e;
    localparam logic [7:0] OP_IASTORE   = 8'h4f;
    localparam logic [7:0] OP_BASTORE   = 8'h54;

    // Stack
    localparam logic [7:0] OP_POP       = 8'h57;
    localparam logic [7:0] OP_DUP       = 8'h59;

    // Integer ALU
    localparam logic [7:0] OP_IADD      = 8'h60;
    localparam logic [7:0] OP_ISUB      = 8'h64;
    localparam logic [7:0] OP_IMUL      = 8'h68;
    localparam logic [7:0] OP_IDIV      = 8'h6c;
    localparam logic [7:0] OP_IREM      = 8'h70;
    localparam logic [7:0] OP_INEG      = 8'h74;
    localparam logic [7:0] OP_ISHL      = 8'h78;
    localparam logic [7:0] OP_ISHR      = 8'h7a;
    localparam logic [7:0] OP_IAND      = 8'h7e;
    localparam logic [7:0] OP_IOR       = 8'h80;
    localparam logic [7:0] OP_IXOR      = 8'h82;
    localparam logic [7:0] OP_IINC      = 8'h84;

    // Branches and returns
    localparam logic [7:0] OP_IFEQ      = 8'h99;
    localparam logic [7:0] OP_IFLE      = 8'h9e;
    localparam logic [7:0] OP_IF_ICMPEQ = 8'h9f;
    localparam logic [7:0] OP_IF_ICMPLE = 8'ha4;
    localparam logic [7:0] OP_GOTO      = 8'ha7;
    localparam logic [7:0] OP_IRETURN   = 8'hac;
    localparam logic [7:0] OP_ARETURN   = 8'hb0;
    localparam logic [7:0] OP_RETURN    = 8'hb1;

    // Same order as the opcode offsets within each branch group
    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_GT,
        CMP_LE
    } cmp_code_t;

    typedef struct packed {
        logic [7:0]        idx;
        logic signed [7:0] cst;
    } jvm_loc_arg_t;

    // Argument bytes as one immediate or as index plus constant
    typedef union packed {
        logic signed [15:0] imm;
        jvm_loc_arg_t       loc;
    } jvm_arg_u;

    typedef struct packed {
        logic [7:0] opcode;
        jvm_arg_u   arg;
    } jvm_instr_t;

endpackage

//--- jvm_core_pkg.sv
`include "jvm_defines.svh"

package jvm_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_MUL  = 4'd2,
        ALU_NEG  = 4'd3,
        ALU_SHL  = 4'd4,
        ALU_SHR  = 4'd5,
        ALU_AND  = 4'd6,
        ALU_OR   = 4'd7,
        ALU_XOR  = 4'd8,
        ALU_PASS = 4'd9
    } alu_op_t;

    typedef struct packed {
        logic [1:0]                stack_args;
        logic                      stack_wb;
        logic                      const_push;
        logic [`JVM_DATA_W-1:0]    const_val;
        logic                      arg_push;
        logic                      is_alu;
        alu_op_t                   alu_op;
        logic                      is_cmp;
        logic                      cmp_two;
        jvm_isa_pkg::cmp_code_t    cmp_code;
        logic                      is_goto;
        logic                      local_rd;
        logic                      local_wr;
        logic                      local_inc;
        logic [`JVM_LIDX_W-1:0]    local_idx;
        logic                      illegal;
    } jvm_ctrl_t;

    typedef struct packed {
        logic [`JVM_DATA_W-1:0]  tos;
        logic [`JVM_DEPTH_W-1:0] depth;
        logic                    br_taken;
        logic signed [15:0]      br_offset;
        logic                    fault_under;
        logic                    fault_over;
        logic                    fault_illegal;
    } jvm_result_t;

endpackage

//--- jvm_decoder.sv
`include "jvm_defines.svh"
`timescale 1ns/10ps

module jvm_decoder (
    input  jvm_isa_pkg::jvm_instr_t instr,
    output jvm_core_pkg::jvm_ctrl_t ctrl
);
    import jvm_isa_pkg::*;
    import jvm_core_pkg::*;

    localparam int DW   = `JVM_DATA_W;
    localparam int LW   = `JVM_LIDX_W;
    localparam int NLOC = `JVM_NUM_LOCALS;

    logic idx_bad;
    logic unsupported;

    // Index byte past the local file
    assign idx_bad = instr.arg.loc.idx >= 8'(NLOC);

    // Known opcodes with no hardware behind them
    assign unsupported = instr.opcode inside {OP_LDC, OP_ALOAD, OP_IALOAD, OP_BALOAD,
                                              OP_ASTORE, OP_IASTORE, OP_BASTORE,
                                              OP_IDIV, OP_IREM,
                                              OP_IRETURN, OP_ARETURN, OP_RETURN};

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = ALU_PASS;
        ctrl.cmp_code = CMP_EQ;
        casez (instr.opcode)
            8'h0?: begin
                if (instr.opcode inside {[OP_ICONST_M1:OP_ICONST_5]}) begin
                    ctrl.stack_wb = 1'b1;
                    ctrl.const_push = 1'b1;
                    ctrl.const_val = DW'($signed(instr.opcode - OP_ICONST_0));
                end else if (instr.opcode != OP_NOP) begin
                    ctrl.illegal = 1'b1;
                end
            end
            8'h1?: begin
                if (instr.opcode inside {[OP_ILOAD_0:OP_ILOAD_3]}) begin
                    ctrl.stack_wb = 1'b1;
                    ctrl.local_rd = 1'b1;
                    ctrl.local_idx = LW'(instr.opcode - OP_ILOAD_0);
                end else begin
                    case (instr.opcode)
                        OP_BIPUSH: begin
                            // Single argument byte sits in the low half
                            ctrl.stack_wb = 1'b1;
                            ctrl.arg_push = 1'b1;
                            ctrl.const_val = DW'($signed(instr.arg.imm[7:0]));
                        end
                        OP_SIPUSH: begin
                            ctrl.stack_wb = 1'b1;
                            ctrl.arg_push = 1'b1;
                            ctrl.const_val = DW'(instr.arg.imm);
                        end
                        OP_ILOAD: begin
                            ctrl.stack_wb = 1'b1;
                            ctrl.local_rd = 1'b1;
                            ctrl.local_idx = LW'(instr.arg.loc.idx);
                            ctrl.illegal = idx_bad;
                        end
                        default: ctrl.illegal = 1'b1;
                    endcase
                end
            end
            8'h3?: begin
                if (instr.opcode inside {[OP_ISTORE_0:OP_ISTORE_3]}) begin
                    ctrl.stack_args = 2'd1;
                    ctrl.local_wr = 1'b1;
                    ctrl.local_idx = LW'(instr.opcode - OP_ISTORE_0);
                end else if (instr.opcode == OP_ISTORE) begin
                    ctrl.stack_args = 2'd1;
                    ctrl.local_wr = 1'b1;
                    ctrl.local_idx = LW'(instr.arg.loc.idx);
                    ctrl.illegal = idx_bad;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            8'h5?: begin
                case (instr.opcode)
                    OP_POP: ctrl.stack_args = 2'd1;
                    OP_DUP: begin
                        // Copies the top word, nothing popped
                        ctrl.stack_wb = 1'b1;
                        ctrl.is_alu = 1'b1;
                        ctrl.alu_op = ALU_PASS;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            8'h6?: begin
                // IADD, ISUB, IMUL from bits 3:2
                if (instr.opcode[1:0] == 2'b00 && !unsupported) begin
                    ctrl.stack_args = 2'd2;
                    ctrl.stack_wb = 1'b1;
                    ctrl.is_alu = 1'b1;
                    ctrl.alu_op = alu_op_t'({2'b00, instr.opcode[3:2]});
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            8'h7?: begin
                ctrl.stack_args = 2'd2;
                ctrl.stack_wb = 1'b1;
                ctrl.is_alu = 1'b1;
                case (instr.opcode)
                    OP_INEG: begin
                        ctrl.stack_args = 2'd1;
                        ctrl.alu_op = ALU_NEG;
                    end
                    OP_ISHL: ctrl.alu_op = ALU_SHL;
                    OP_ISHR: ctrl.alu_op = ALU_SHR;
                    OP_IAND: ctrl.alu_op = ALU_AND;
                    default: begin
                        ctrl = '0;
                        ctrl.illegal = 1'b1;
                    end
                endcase
            end
            8'b10??????: begin
                if (instr.opcode inside {[OP_IFEQ:OP_IFLE]}) begin
                    ctrl.is_cmp = 1'b1;
                    ctrl.stack_args = 2'd1;
                    ctrl.cmp_code = cmp_code_t'(3'(instr.opcode - OP_IFEQ));
                end else if (instr.opcode inside {[OP_IF_ICMPEQ:OP_IF_ICMPLE]}) begin
                    ctrl.is_cmp = 1'b1;
                    ctrl.cmp_two = 1'b1;
                    ctrl.stack_args = 2'd2;
                    ctrl.cmp_code = cmp_code_t'(3'(instr.opcode - OP_IF_ICMPEQ));
                end else begin
                    // IOR, IXOR and IINC share the 10 prefix
                    case (instr.opcode)
                        OP_IOR, OP_IXOR: begin
                            ctrl.stack_args = 2'd2;
                            ctrl.stack_wb = 1'b1;
                            ctrl.is_alu = 1'b1;
                            ctrl.alu_op = instr.opcode[1] ? ALU_XOR : ALU_OR;
                        end
                        OP_IINC: begin
                            ctrl.local_inc = 1'b1;
                            ctrl.local_idx = LW'(instr.arg.loc.idx);
                            ctrl.const_val = DW'(instr.arg.loc.cst);
                            ctrl.illegal = idx_bad;
                        end
                        OP_GOTO: ctrl.is_goto = 1'b1;
                        default: ctrl.illegal = 1'b1;
                    endcase
                end
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

//--- jvm_execute.sv
`include "jvm_defines.svh"
`timescale 1ns/10ps

module jvm_execute (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid,
    input  jvm_isa_pkg::jvm_instr_t    instr,
    input  jvm_core_pkg::jvm_ctrl_t    ctrl,
    output logic                       step_done,
    output jvm_core_pkg::jvm_result_t  step
);
    import jvm_isa_pkg::*;
    import jvm_core_pkg::*;

    localparam int DW    = `JVM_DATA_W;
    localparam int DEPTH = `JVM_STACK_DEPTH;
    localparam int NLOC  = `JVM_NUM_LOCALS;
    localparam int PW    = `JVM_DEPTH_W;
    localparam int SW    = PW - 1;
    localparam int XW    = PW + 1;

    logic [DW-1:0]        stack_mem [DEPTH];
    logic [DW-1:0]        locals [NLOC];
    logic [PW-1:0]        depth;
    logic [DW-1:0]        top;
    logic [DW-1:0]        second;
    logic [1:0]           need;
    logic [XW-1:0]        depth_pop;
    logic [XW-1:0]        depth_raw;
    logic [PW-1:0]        depth_nxt;
    logic                 under;
    logic                 over;
    logic                 fault;
    logic [DW-1:0]        alu_res;
    logic [DW-1:0]        new_val;
    logic [DW-1:0]        tos_nxt;
    logic signed [DW-1:0] cmp_l;
    logic signed [DW-1:0] cmp_r;
    logic                 cmp_hold;
    logic                 taken;

    // Top entry lives at depth-1
    assign top = stack_mem[SW'(depth - PW'(1))];
    assign second = stack_mem[SW'(depth - PW'(2))];

    // DUP and INEG read one word
    always_comb begin
        if (ctrl.is_alu) begin
            need = (ctrl.alu_op == ALU_NEG || ctrl.alu_op == ALU_PASS) ? 2'd1 : 2'd2;
        end else begin
            need = ctrl.stack_args;
        end
    end

    assign depth_pop = {1'b0, depth} - XW'(ctrl.stack_args);
    assign depth_raw = depth_pop + XW'(ctrl.stack_wb);
    assign under = depth < PW'(need);
    assign over = depth_raw > XW'(DEPTH);
    assign fault = under | over | ctrl.illegal;
    assign depth_nxt = fault ? depth : PW'(depth_raw);

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: alu_res = second + top;
            ALU_SUB: alu_res = second - top;
            ALU_MUL: alu_res = second * top;
            ALU_NEG: alu_res = -top;
            ALU_SHL: alu_res = second << top[4:0];
            ALU_SHR: alu_res = $signed(second) >>> top[4:0];
            ALU_AND: alu_res = second & top;
            ALU_OR:  alu_res = second | top;
            ALU_XOR: alu_res = second ^ top;
            default: alu_res = top;
        endcase
    end

    // Second against top, or top against zero
    always_comb begin
        cmp_l = ctrl.cmp_two ? second : top;
        cmp_r = ctrl.cmp_two ? top : '0;
        case (ctrl.cmp_code)
            CMP_EQ:  cmp_hold = cmp_l == cmp_r;
            CMP_NE:  cmp_hold = cmp_l != cmp_r;
            CMP_LT:  cmp_hold = cmp_l < cmp_r;
            CMP_GE:  cmp_hold = cmp_l >= cmp_r;
            CMP_GT:  cmp_hold = cmp_l > cmp_r;
            CMP_LE:  cmp_hold = cmp_l <= cmp_r;
            default: cmp_hold = 1'b0;
        endcase
    end

    assign taken = !fault && ((ctrl.is_cmp && cmp_hold) || ctrl.is_goto);

    always_comb begin
        if (ctrl.const_push || ctrl.arg_push) begin
            new_val = ctrl.const_val;
        end else if (ctrl.local_rd) begin
            new_val = locals[ctrl.local_idx];
        end else begin
            new_val = alu_res;
        end
    end

    always_comb begin
        if (depth_nxt == '0) begin
            tos_nxt = '0;
        end else if (!fault && ctrl.stack_wb) begin
            tos_nxt = new_val;
        end else begin
            tos_nxt = stack_mem[SW'(depth_nxt - PW'(1))];
        end
    end

    always_ff @(posedge clk) begin
        if (valid && !fault && ctrl.stack_wb) begin
            stack_mem[SW'(depth_pop)] <= new_val;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            depth <= '0;
            step_done <= 1'b0;
            for (int i = 0; i < NLOC; i++) begin
                locals[i] <= '0;
            end
        end else begin
            step_done <= valid;
            if (valid && !fault) begin
                depth <= depth_nxt;
                if (ctrl.local_wr) begin
                    locals[ctrl.local_idx] <= top;
                end
                if (ctrl.local_inc) begin
                    locals[ctrl.local_idx] <= locals[ctrl.local_idx] + ctrl.const_val;
                end
            end
        end
    end

    // Raw fault bits, the result stage picks one
    always_ff @(posedge clk) begin
        if (valid) begin
            step.tos <= tos_nxt;
            step.depth <= depth_nxt;
            step.br_taken <= taken;
            step.br_offset <= (ctrl.is_cmp || ctrl.is_goto) ? instr.arg.imm : '0;
            step.fault_under <= under;
            step.fault_over <= over;
            step.fault_illegal <= ctrl.illegal;
        end
    end

endmodule

//--- jvm_result.sv
`timescale 1ns/10ps

module jvm_result (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       step_done,
    input  jvm_core_pkg::jvm_result_t  step,
    output logic                       out_valid,
    output jvm_core_pkg::jvm_result_t  out_result
);
    import jvm_core_pkg::*;

    jvm_result_t summary;

    // Illegal wins, then underflow, then overflow
    always_comb begin
        summary = step;
        summary.fault_under = step.fault_under & ~step.fault_illegal;
        summary.fault_over = step.fault_over & ~step.fault_under & ~step.fault_illegal;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= step_done;
        end
    end

    // Holds the last outcome between strobes
    always_ff @(posedge clk) begin
        if (step_done) begin
            out_result <= summary;
        end
    end

endmodule

//--- jvm_core.sv
`timescale 1ns/10ps

module jvm_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  jvm_isa_pkg::jvm_instr_t    in_instr,
    output logic                       out_valid,
    output jvm_core_pkg::jvm_result_t  out_result
);
    import jvm_core_pkg::*;

    jvm_ctrl_t   ctrl;
    logic        step_done;
    jvm_result_t step;

    // Decode in the strobe cycle
    jvm_decoder u_decoder (
        .instr (in_instr),
        .ctrl  (ctrl)
    );

    jvm_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (in_valid),
        .instr     (in_instr),
        .ctrl      (ctrl),
        .step_done (step_done),
        .step      (step)
    );

    jvm_result u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .step_done  (step_done),
        .step       (step),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

//--- jvm_core_chk.sv
`include "jvm_defines.svh"
`timescale 1ns/10ps

module jvm_core_chk (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       in_valid,
    input jvm_isa_pkg::jvm_instr_t    in_instr,
    input logic                       out_valid,
    input jvm_core_pkg::jvm_result_t  out_result
);
    import jvm_isa_pkg::*;

    localparam int DW = `JVM_DATA_W;
    localparam int PW = `JVM_DEPTH_W;

    int unsigned   err_count = 0;
    logic          v_d1;
    logic          v_d2;
    jvm_instr_t    i_d1;
    jvm_instr_t    cur;
    logic [7:0]    op;
    logic          push_p1;
    logic          push_p2;
    logic [DW-1:0] tos_p1;
    logic [DW-1:0] tos_p2;
    logic [PW-1:0] depth_p1;
    logic          st_ok;
    logic [7:0]    st_idx;
    logic [DW-1:0] st_val;
    logic          any_fault;
    logic          full;
    logic          chk_const;
    logic          chk_alu;
    logic          chk_load;
    logic          chk_br;
    logic          chk_under;
    logic          chk_over;
    logic          chk_illegal;
    logic [DW-1:0] exp_const;
    logic [DW-1:0] exp_alu;
    logic [PW-1:0] exp_depth;
    logic          exp_taken;

    function automatic logic is_const(input logic [7:0] opc);
        return opc inside {[OP_ICONST_M1:OP_ICONST_5], OP_BIPUSH, OP_SIPUSH};
    endfunction

    function automatic logic [DW-1:0] const_of(input jvm_instr_t ins);
        if (ins.opcode == OP_BIPUSH) begin
            return DW'(int'($signed(ins.arg.imm[7:0])));
        end
        if (ins.opcode == OP_SIPUSH) begin
            return DW'(int'(ins.arg.imm));
        end
        return DW'(int'(ins.opcode) - int'(OP_ICONST_0));
    endfunction

    // Local index from the argument byte or the short form
    function automatic logic [7:0] idx_of(input jvm_instr_t ins, input logic [7:0] base);
        if (ins.opcode inside {OP_ILOAD, OP_ISTORE}) begin
            return ins.arg.loc.idx;
        end
        return ins.opcode - base;
    endfunction

    function automatic logic [DW-1:0] alu_expect(input logic [7:0] opc,
                                                 input logic [DW-1:0] a,
                                                 input logic [DW-1:0] b);
        case (opc)
            OP_IADD: return a + b;
            OP_ISUB: return a - b;
            OP_IMUL: return a * b;
            OP_INEG: return -b;
            OP_ISHL: return a << b[4:0];
            OP_ISHR: return $signed(a) >>> b[4:0];
            OP_IAND: return a & b;
            OP_IOR:  return a | b;
            OP_IXOR: return a ^ b;
            default: return '0;
        endcase
    endfunction

    // Order of conditions is EQ NE LT GE GT LE
    function automatic logic cmp_holds(input int code, input logic signed [DW-1:0] l,
                                       input logic signed [DW-1:0] r);
        case (code)
            0: return l == r;
            1: return l != r;
            2: return l < r;
            3: return l >= r;
            4: return l > r;
            5: return l <= r;
            default: return 1'b0;
        endcase
    endfunction

    always_comb begin
        op = cur.opcode;
        any_fault = out_result.fault_under | out_result.fault_over | out_result.fault_illegal;
        full = depth_p1 == PW'(`JVM_STACK_DEPTH);
        chk_const = out_valid && !full && is_const(op);
        exp_const = const_of(cur);
        chk_alu = out_valid && push_p1 && ((op == OP_INEG) ||
                  (push_p2 && op inside {OP_IADD, OP_ISUB, OP_IMUL, OP_ISHL, OP_ISHR,
                                         OP_IAND, OP_IOR, OP_IXOR}));
        exp_alu = alu_expect(op, tos_p2, tos_p1);
        exp_depth = chk_const ? depth_p1 + PW'(1) :
                    (op == OP_INEG) ? depth_p1 : depth_p1 - PW'(1);
        chk_load = out_valid && !full && st_ok &&
                   (op == OP_ILOAD || op inside {[OP_ILOAD_0:OP_ILOAD_3]})
                   && idx_of(cur, OP_ILOAD_0) == st_idx;
        chk_br = out_valid && ((op == OP_GOTO) ||
                 (op inside {[OP_IFEQ:OP_IFLE]} && push_p1) ||
                 (op inside {[OP_IF_ICMPEQ:OP_IF_ICMPLE]} && push_p1 && push_p2));
        if (op == OP_GOTO) begin
            exp_taken = 1'b1;
        end else if (op inside {[OP_IFEQ:OP_IFLE]}) begin
            exp_taken = cmp_holds(int'(op) - int'(OP_IFEQ), tos_p1, '0);
        end else begin
            exp_taken = cmp_holds(int'(op) - int'(OP_IF_ICMPEQ), tos_p2, tos_p1);
        end
        chk_under = out_valid && op == OP_POP && depth_p1 == '0;
        chk_over = out_valid && full && is_const(op);
        chk_illegal = out_valid && (op == OP_IDIV || op == 8'hff);
    end

    always_ff @(posedge clk) begin
        i_d1 <= in_instr;
        cur <= i_d1;
    end

    // History of the last two reported results
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v_d1 <= 1'b0;
            v_d2 <= 1'b0;
            push_p1 <= 1'b0;
            push_p2 <= 1'b0;
            tos_p1 <= '0;
            tos_p2 <= '0;
            depth_p1 <= '0;
            st_ok <= 1'b0;
            st_idx <= '0;
            st_val <= '0;
        end else begin
            v_d1 <= in_valid;
            v_d2 <= v_d1;
            if (out_valid) begin
                push_p1 <= chk_const;
                push_p2 <= push_p1;
                tos_p1 <= out_result.tos;
                tos_p2 <= tos_p1;
                depth_p1 <= out_result.depth;
                if (depth_p1 != '0 && idx_of(cur, OP_ISTORE_0) < 8'(`JVM_NUM_LOCALS) &&
                    (op == OP_ISTORE || op inside {[OP_ISTORE_0:OP_ISTORE_3]})) begin
                    st_ok <= 1'b1;
                    st_idx <= idx_of(cur, OP_ISTORE_0);
                    st_val <= tos_p1;
                end else if (op == OP_IINC && cur.arg.loc.idx == st_idx) begin
                    st_val <= st_val + DW'(int'(cur.arg.loc.cst));
                end
            end
        end
    end

    a_reset: assert property (@(posedge clk) !$past(rst_n) |-> !out_valid)
        else begin
            err_count++;
            $error("out_valid was high while reset was held");
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n) out_valid == v_d2)
        else begin
            err_count++;
            $error("out_valid did not come exactly two cycles after in_valid");
        end

    a_clean: assert property (@(posedge clk) disable iff (!rst_n)
                              (chk_const || chk_alu || chk_load || chk_br) |-> !any_fault)
        else begin
            err_count++;
            $error("A result that should have been free of faults carried a fault bit");
        end

    a_const: assert property (@(posedge clk) disable iff (!rst_n)
                              chk_const |-> out_result.tos == exp_const)
        else begin
            err_count++;
            $error("Fail const_push expected %0h actual %0h",
                   $sampled(exp_const), $sampled(out_result.tos));
        end

    a_alu: assert property (@(posedge clk) disable iff (!rst_n)
                            chk_alu |-> out_result.tos == exp_alu)
        else begin
            err_count++;
            $error("Fail alu expected %0h actual %0h",
                   $sampled(exp_alu), $sampled(out_result.tos));
        end

    a_depth: assert property (@(posedge clk) disable iff (!rst_n)
                              (chk_const || chk_alu) |-> out_result.depth == exp_depth)
        else begin
            err_count++;
            $error("Fail depth expected %0d actual %0d",
                   $sampled(exp_depth), $sampled(out_result.depth));
        end

    a_load: assert property (@(posedge clk) disable iff (!rst_n)
                             chk_load |-> out_result.tos == st_val)
        else begin
            err_count++;
            $error("Fail locals expected %0h actual %0h",
                   $sampled(st_val), $sampled(out_result.tos));
        end

    a_branch: assert property (@(posedge clk) disable iff (!rst_n)
                               chk_br |-> out_result.br_taken == exp_taken)
        else begin
            err_count++;
            $error("Fail branch expected %0b actual %0b",
                   $sampled(exp_taken), $sampled(out_result.br_taken));
        end

    a_offset: assert property (@(posedge clk) disable iff (!rst_n)
                               chk_br |-> out_result.br_offset == cur.arg.imm)
        else begin
            err_count++;
            $error("Fail branch_offset expected %0h actual %0h",
                   $sampled(cur.arg.imm), $sampled(out_result.br_offset));
        end

    a_under: assert property (@(posedge clk) disable iff (!rst_n)
                              chk_under |-> out_result.fault_under &&
                              !out_result.fault_over && !out_result.fault_illegal &&
                              out_result.depth == '0)
        else begin
            err_count++;
            $error("POP on an empty stack did not report underflow alone at depth 0");
        end

    a_over: assert property (@(posedge clk) disable iff (!rst_n)
                             chk_over |-> out_result.fault_over &&
                             out_result.depth == PW'(`JVM_STACK_DEPTH))
        else begin
            err_count++;
            $error("Push on a full stack did not report overflow at full depth");
        end

    a_illegal: assert property (@(posedge clk) disable iff (!rst_n)
                                chk_illegal |-> out_result.fault_illegal &&
                                out_result.tos == tos_p1)
        else begin
            err_count++;
            $error("Unsupported opcode was not flagged or changed the top of stack");
        end

endmodule

bind jvm_core jvm_core_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_instr   (in_instr),
    .out_valid  (out_valid),
    .out_result (out_result)
);

//--- jvm_core_tb.sv
`timescale 1ns/10ps

module jvm_core_tb;
    import jvm_isa_pkg::*;
    import jvm_core_pkg::*;

    // Reset, about 130 strobes and idle cycles, and the drain
    localparam int STIM_CYCLES = 140;
    localparam int LIMIT = 2 * STIM_CYCLES + 50;
    localparam logic [7:0] BIN_OPS [8] = '{OP_IADD, OP_ISUB, OP_IMUL, OP_ISHL,
                                           OP_ISHR, OP_IAND, OP_IOR, OP_IXOR};

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    jvm_instr_t  in_instr;
    logic        out_valid;
    jvm_result_t out_result;
    logic [15:0] lfsr = 16'd65;
    int          sent = 0;
    int          seen = 0;
    int          cycles = 0;

    jvm_core u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[14:0], lfsr[0]};
        end
    endtask

    task automatic issue(input logic [7:0] opc, input logic [15:0] arg);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_instr.opcode = opc;
        in_instr.arg.imm = arg;
        sent++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    // Result counting, timeout and the assertion hook
    always @(negedge clk) begin
        cycles++;
        if (out_valid) begin
            seen++;
        end
        if (u_dut.u_chk.err_count != 0) begin
            $display("Regression failed");
            $fatal(1, "An assertion on the DUT results failed");
        end else if (cycles >= LIMIT) begin
            $display("Regression failed");
            $fatal(1, "Timeout after %0d cycles with %0d of %0d results", cycles, seen, sent);
        end
    end

    initial begin
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] off;
        in_valid = 1'b0;
        in_instr = '0;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        issue(OP_POP, '0);
        idle(2);

        // Fill past the top, then drain
        repeat (17) issue(OP_ICONST_0, '0);
        repeat (16) issue(OP_POP, '0);

        rand_bits(8, a);
        rand_bits(16, b);
        issue(OP_ICONST_M1, '0);
        issue(OP_ICONST_5, '0);
        issue(OP_BIPUSH, a);
        issue(OP_SIPUSH, b);
        repeat (4) issue(OP_POP, '0);

        for (int k = 0; k < 8; k++) begin
            rand_bits(16, a);
            rand_bits(16, b);
            issue(OP_SIPUSH, a);
            issue(OP_SIPUSH, b);
            issue(BIN_OPS[k], '0);
            issue(OP_POP, '0);
        end
        rand_bits(16, a);
        issue(OP_SIPUSH, a);
        issue(OP_INEG, '0);
        issue(OP_POP, '0);

        rand_bits(16, a);
        issue(OP_SIPUSH, a);
        issue(OP_ISTORE, {8'd5, 8'd0});
        issue(OP_ILOAD, {8'd5, 8'd0});
        issue(OP_POP, '0);
        issue(OP_IINC, {8'd5, 8'hfd});
        issue(OP_ILOAD, {8'd5, 8'd0});
        issue(OP_POP, '0);
        rand_bits(8, a);
        issue(OP_BIPUSH, a);
        issue(OP_ISTORE_0 + 8'd2, '0);
        issue(OP_ILOAD_0 + 8'd2, '0);
        issue(OP_POP, '0);

        // Small operands so that equal pairs and negatives show up
        for (int c = 0; c < 6; c++) begin
            rand_bits(2, a);
            rand_bits(2, b);
            rand_bits(16, off);
            issue(OP_BIPUSH, {8'd0, 8'(a) - 8'd2});
            issue(OP_BIPUSH, {8'd0, 8'(b) - 8'd2});
            issue(OP_IF_ICMPEQ + 8'(c), off);
        end
        for (int c = 0; c < 6; c++) begin
            rand_bits(2, a);
            rand_bits(16, off);
            issue(OP_BIPUSH, {8'd0, 8'(a) - 8'd2});
            issue(OP_IFEQ + 8'(c), off);
        end
        rand_bits(16, off);
        issue(OP_GOTO, off);

        issue(OP_ICONST_5, '0);
        issue(OP_ICONST_M1, '0);
        issue(OP_IDIV, '0);
        issue(8'hff, '0);
        issue(OP_POP, '0);
        issue(OP_POP, '0);
        idle(1);

        while (seen < sent) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (u_dut.u_chk.err_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "Assertion failures were recorded");
        end
    end

endmodule

//--- flist.f
+incdir+.
jvm_isa_pkg.sv
jvm_core_pkg.sv
jvm_decoder.sv
jvm_execute.sv
jvm_result.sv
jvm_core.sv
jvm_core_chk.sv
jvm_core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module jvm_core_tb -f flist.f -o jvm_sim

# The simulator exits nonzero on failure, the log search decides
./obj_dir/jvm_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -q "Regression passed" sim.log
